/* hdl/rvDecodePkg.sv */
package rvDecodePkg;

    // immediate layout selector with the immGen bit patterns
    typedef enum logic [2:0] {
        immI = 3'b000,
        immJ = 3'b001,
        immS = 3'b010,
        immB = 3'b011,
        immU = 3'b101
    } immFmtE;

    typedef enum logic [2:0] {
        brNone = 3'b000,
        brJal  = 3'b001,
        brJalr = 3'b010,
        brEq   = 3'b100,
        brNe   = 3'b101,
        brLt   = 3'b110,
        brGe   = 3'b111
    } branchE;

    typedef struct packed {
        logic [5:0] aluCtrl;  // [5] mul/div, [4] word op, [3:0] function
        logic       aluASrc;  // pc instead of rs1
        logic [1:0] aluBSrc;  // 0 rs2, 1 const 4, 2 imm
        branchE     branch;
        logic       memRd;
        logic       memWr;
        logic       memToReg;
        logic       regWr;
        logic [2:0] memOp;    // funct3 as is
    } ctrlT;

    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] instr;
        logic        busErr;
    } fetchT;

    typedef struct packed {
        logic [63:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [63:0] imm;
        ctrlT        ctrl;
        logic        isCsr;
        logic [11:0] csrAddr;
        logic        ecall;
        logic        mret;
        logic        done;     // ebreak seen
        logic        illegal;
        logic        busErr;
    } decodedT;

    typedef struct packed {
        logic        arvalid;
        logic [63:0] araddr;
        logic [2:0]  arprot;
    } axiArT;

    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axiRT;

endpackage

/* hdl/immGen.sv */
`timescale 1ns/1ps

module immGen (
    input  logic [31:7]         instrHi,
    input  rvDecodePkg::immFmtE immFmt,
    output logic [63:0]         imm
);
    logic sign;
    logic isU;
    logic isJ;
    logic isS;
    logic isB;

    assign sign = instrHi[31];
    assign isU  = immFmt == rvDecodePkg::immU;
    assign isJ  = immFmt == rvDecodePkg::immJ;
    assign isS  = immFmt == rvDecodePkg::immS;
    assign isB  = immFmt == rvDecodePkg::immB;

    always_comb begin
        imm[63:31] = {33{sign}};
        imm[30:20] = isU ? instrHi[30:20] : {11{sign}};
        imm[19:12] = (isU || isJ) ? instrHi[19:12] : {8{sign}};
        if (isU)
            imm[11] = 1'b0;
        else if (isJ)
            imm[11] = instrHi[20];
        else if (isB)
            imm[11] = instrHi[7];
        else
            imm[11] = sign;  // I and S
        imm[10:5] = isU ? 6'b0 : instrHi[30:25];
        imm[4:1]  = isU ? 4'b0 : ((isS || isB) ? instrHi[11:8] : instrHi[24:21]);
        imm[0]    = (isU || isJ || isB) ? 1'b0 : (isS ? instrHi[7] : instrHi[20]);
    end

endmodule

/* hdl/ctrlDecode.sv */
`timescale 1ns/1ps

module ctrlDecode (
    input  logic [6:0]          opcode,
    input  logic [2:0]          funct3,
    input  logic [6:0]          funct7,
    output rvDecodePkg::immFmtE immFmt,
    output rvDecodePkg::ctrlT   ctrl,
    output logic                isCsr,
    output logic                illegal
);
    localparam logic [4:0] opLoad   = 5'b00000;
    localparam logic [4:0] opImm    = 5'b00100;
    localparam logic [4:0] opAuipc  = 5'b00101;
    localparam logic [4:0] opImm32  = 5'b00110;
    localparam logic [4:0] opStore  = 5'b01000;
    localparam logic [4:0] opOp     = 5'b01100;
    localparam logic [4:0] opLui    = 5'b01101;
    localparam logic [4:0] opOp32   = 5'b01110;
    localparam logic [4:0] opBranch = 5'b11000;
    localparam logic [4:0] opJalr   = 5'b11001;
    localparam logic [4:0] opJal    = 5'b11011;
    localparam logic [4:0] opSystem = 5'b11100;

    logic [4:0] op;
    logic       f7Zero;
    logic       f7Alt;
    logic       f7Mul;
    logic       err;

    assign op      = opcode[6:2];
    assign f7Zero  = funct7 == 7'b0000000;
    assign f7Alt   = funct7 == 7'b0100000;  // sub / sra
    assign f7Mul   = funct7 == 7'b0000001;
    assign isCsr   = op == opSystem;
    assign illegal = err || opcode[1:0] != 2'b11;

    always_comb begin
        immFmt          = rvDecodePkg::immI;
        ctrl.aluCtrl    = 6'b0;
        ctrl.aluCtrl[5] = (op == opOp || op == opOp32) && funct7[0];
        ctrl.aluCtrl[4] = op == opImm32 || op == opOp32;
        ctrl.aluASrc    = op == opAuipc || op == opJal || op == opJalr;
        ctrl.aluBSrc    = 2'd0;
        ctrl.branch     = rvDecodePkg::brNone;
        ctrl.memRd      = op == opLoad;
        ctrl.memWr      = op == opStore;
        ctrl.memToReg   = op == opLoad;
        ctrl.regWr      = op != opBranch && op != opStore;
        ctrl.memOp      = funct3;
        err             = 1'b0;
        case (op)
            opSystem: begin
                ctrl.aluBSrc      = 2'd2;
                ctrl.aluCtrl[3:0] = 4'b1111;
                err               = funct3 == 3'b100;
            end
            opLui: begin
                immFmt            = rvDecodePkg::immU;
                ctrl.aluBSrc      = 2'd2;
                ctrl.aluCtrl[3:0] = 4'b1111;  // pass imm
            end
            opAuipc: begin
                immFmt       = rvDecodePkg::immU;
                ctrl.aluBSrc = 2'd2;
            end
            opJal: begin
                immFmt       = rvDecodePkg::immJ;
                ctrl.aluBSrc = 2'd1;  // link = pc + 4
                ctrl.branch  = rvDecodePkg::brJal;
            end
            opJalr: begin
                ctrl.aluBSrc = 2'd1;
                ctrl.branch  = rvDecodePkg::brJalr;
                err          = funct3 != 3'b000;
            end
            opBranch: begin
                immFmt            = rvDecodePkg::immB;
                ctrl.aluCtrl[3:0] = 4'b0010;
                case (funct3)
                    3'b000: ctrl.branch = rvDecodePkg::brEq;
                    3'b001: ctrl.branch = rvDecodePkg::brNe;
                    3'b100: ctrl.branch = rvDecodePkg::brLt;
                    3'b101: ctrl.branch = rvDecodePkg::brGe;
                    3'b110: begin
                        ctrl.branch       = rvDecodePkg::brLt;
                        ctrl.aluCtrl[3:0] = 4'b0011;  // unsigned
                    end
                    3'b111: begin
                        ctrl.branch       = rvDecodePkg::brGe;
                        ctrl.aluCtrl[3:0] = 4'b0011;
                    end
                    default: begin
                        ctrl.aluCtrl[3:0] = 4'b0000;
                        err               = 1'b1;
                    end
                endcase
            end
            opLoad: begin
                ctrl.aluBSrc = 2'd2;
                err          = funct3 == 3'b111;
            end
            opStore: begin
                immFmt       = rvDecodePkg::immS;
                ctrl.aluBSrc = 2'd2;
                err          = funct3[2];
            end
            opImm: begin
                ctrl.aluBSrc      = 2'd2;
                ctrl.aluCtrl[3:0] = {funct7[5] && funct3 == 3'b101, funct3};
                err = (funct3 == 3'b001 && funct7[6:1] != 6'b000000)
                    || (funct3 == 3'b101 && funct7[6:1] != 6'b000000
                        && funct7[6:1] != 6'b010000);  // 6-bit shamt
            end
            opImm32: begin
                ctrl.aluBSrc      = 2'd2;
                ctrl.aluCtrl[3:0] = {funct7[5] && funct3 == 3'b101, funct3};
                err = !(funct3 == 3'b000 || (funct3 == 3'b001 && f7Zero)
                    || (funct3 == 3'b101 && (f7Zero || f7Alt)));
            end
            opOp: begin
                ctrl.aluCtrl[3:0] = {funct7[5], funct3};
                err = !(f7Zero || f7Mul
                    || (f7Alt && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            opOp32: begin
                ctrl.aluCtrl[3:0] = {funct7[5], funct3};
                err = !((f7Zero && (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101))
                    || (f7Alt && (funct3 == 3'b000 || funct3 == 3'b101))
                    || (f7Mul && (funct3 == 3'b000 || funct3[2])));
            end
            default: err = 1'b1;
        endcase
    end

endmodule

/* hdl/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
    input  logic [31:0]          instr,
    input  logic [63:0]          pc,
    input  logic                 busErr,
    output rvDecodePkg::decodedT decoded
);
    localparam logic [31:0] ecallWord  = 32'h0000_0073;
    localparam logic [31:0] ebreakWord = 32'h0010_0073;
    localparam logic [31:0] mretWord   = 32'h3020_0073;

    rvDecodePkg::immFmtE immFmt;
    rvDecodePkg::ctrlT   ctrl;
    logic [63:0]         imm;
    logic                isCsr;
    logic                ctrlIllegal;
    logic                isEcall;
    logic                isEbreak;
    logic                isMret;
    logic                badSystem;

    ctrlDecode ctrlDec (
        .opcode  (instr[6:0]),
        .funct3  (instr[14:12]),
        .funct7  (instr[31:25]),
        .immFmt  (immFmt),
        .ctrl    (ctrl),
        .isCsr   (isCsr),
        .illegal (ctrlIllegal)
    );

    immGen immG (
        .instrHi (instr[31:7]),
        .immFmt  (immFmt),
        .imm     (imm)
    );

    assign isEcall  = instr == ecallWord;
    assign isEbreak = instr == ebreakWord;
    assign isMret   = instr == mretWord;
    // funct3 000 in SYSTEM only allows the three privileged words
    assign badSystem = isCsr && instr[14:12] == 3'b000 && !(isEcall || isEbreak || isMret);

    always_comb begin
        decoded.pc      = pc;
        decoded.rs1     = instr[19:15];
        decoded.rs2     = instr[24:20];
        decoded.rd      = instr[11:7];
        decoded.imm     = imm;
        decoded.ctrl    = ctrl;
        decoded.isCsr   = isCsr;
        decoded.csrAddr = instr[31:20];
        decoded.ecall   = isEcall;
        decoded.mret    = isMret;
        decoded.done    = isEbreak;
        decoded.illegal = ctrlIllegal || badSystem || busErr;
        decoded.busErr  = busErr;
    end

endmodule

/* hdl/instrFetch.sv */
`timescale 1ns/1ps

module instrFetch #(
    parameter logic [63:0] bootAddr = 64'h0000_0000_8000_0000
) (
    input  logic               clk,
    input  logic               rstN,
    output rvDecodePkg::axiArT ar,
    input  logic               arReady,
    input  rvDecodePkg::axiRT  r,
    output logic               rReady,
    output logic               fetchValid,
    input  logic               fetchReady,
    output rvDecodePkg::fetchT fetchData,
    input  logic               halt
);
    typedef enum logic [1:0] {
        sAddr,
        sWait,
        sHold
    } stateE;

    stateE       state;
    stateE       stateNext;
    logic [63:0] pc;
    logic        haltQ;
    logic        stopIssue;
    logic        rFire;

    assign stopIssue = haltQ || halt;
    // response only taken when the output buffer has room
    assign rReady = state == sWait && (!fetchValid || fetchReady);
    assign rFire  = r.rvalid && rReady;

    // arprot marks an unprivileged secure instruction access
    assign ar = '{arvalid: state == sAddr, araddr: pc, arprot: 3'b100};

    always_comb begin
        stateNext = state;
        case (state)
            sAddr: begin
                if (arReady)
                    stateNext = sWait;  // address stays until taken
            end
            sWait: begin
                if (rFire)
                    stateNext = stopIssue ? sHold : sAddr;
            end
            default: begin
                if (!stopIssue)
                    stateNext = sAddr;  // leaves hold once after reset
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= sHold;
            pc         <= bootAddr;
            haltQ      <= 1'b0;
            fetchValid <= 1'b0;
        end else begin
            state <= stateNext;
            if (halt)
                haltQ <= 1'b1;  // sticky
            if (rFire) begin
                pc         <= pc + 64'd4;
                fetchValid <= 1'b1;
            end else if (fetchReady) begin
                fetchValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rFire) begin
            fetchData.pc     <= pc;
            fetchData.instr  <= r.rdata;
            fetchData.busErr <= r.rresp != 2'b00;  // SLVERR or DECERR
        end
    end

endmodule

/* hdl/pipeReg.sv */
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);
    logic load;

    // free slot or the held item leaves this cycle
    assign inReady = !outValid || outReady;
    assign load    = inValid && inReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            outData <= inData;
        end
    end

endmodule

/* hdl/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage #(
    parameter logic [63:0] bootAddr = 64'h0000_0000_8000_0000
) (
    input  logic                 clk,
    input  logic                 rstN,
    output rvDecodePkg::axiArT   imemAr,
    input  logic                 imemArReady,
    input  rvDecodePkg::axiRT    imemR,
    output logic                 imemRReady,
    output logic                 outValid,
    input  logic                 outReady,
    output rvDecodePkg::decodedT outData
);
    logic                 fetchValid;
    logic                 fetchReady;
    rvDecodePkg::fetchT   fetchData;
    logic                 decValid;
    logic                 decReady;
    rvDecodePkg::fetchT   decIn;
    rvDecodePkg::decodedT decoded;
    logic                 halt;

    // ebreak leaving the stage stops further fetching
    assign halt = outValid && outReady && outData.done;

    instrFetch #(
        .bootAddr (bootAddr)
    ) fetch (
        .clk        (clk),
        .rstN       (rstN),
        .ar         (imemAr),
        .arReady    (imemArReady),
        .r          (imemR),
        .rReady     (imemRReady),
        .fetchValid (fetchValid),
        .fetchReady (fetchReady),
        .fetchData  (fetchData),
        .halt       (halt)
    );

    pipeReg #(
        .payloadT (rvDecodePkg::fetchT)
    ) fetchReg (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (fetchValid),
        .inReady  (fetchReady),
        .inData   (fetchData),
        .outValid (decValid),
        .outReady (decReady),
        .outData  (decIn)
    );

    instrDecode decode (
        .instr   (decIn.instr),
        .pc      (decIn.pc),
        .busErr  (decIn.busErr),
        .decoded (decoded)
    );

    pipeReg #(
        .payloadT (rvDecodePkg::decodedT)
    ) outReg (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (decValid),
        .inReady  (decReady),
        .inData   (decoded),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

endmodule

/* tests/imemModel.sv */
`timescale 1ns/1ps

module imemModel #(
    parameter logic [63:0] baseAddr = 64'h0000_0000_8000_0000,
    parameter int          depth    = 64,
    parameter logic [63:0] errLo    = 64'h0000_0000_8000_0100,
    parameter logic [63:0] errHi    = 64'h0000_0000_8000_0104
) (
    input  logic               clk,
    input  logic               rstN,
    input  rvDecodePkg::axiArT ar,
    output logic               arReady,
    output rvDecodePkg::axiRT  r,
    input  logic               rReady,
    input  logic [1:0]         respDelay  // wait cycles for the next read
);
    localparam logic [63:0] memBytes = depth * 4;

    logic [31:0] words [depth];
    logic        busy;
    logic [1:0]  waitCnt;
    logic [63:0] addrQ;
    logic [63:0] offset;
    logic        inRange;
    logic        inErr;

    assign arReady = !busy;  // one read at a time
    assign offset  = addrQ - baseAddr;
    assign inRange = addrQ >= baseAddr && offset < memBytes;
    assign inErr   = addrQ >= errLo && addrQ < errHi;

    task automatic writeWord(input int idx, input logic [31:0] w);
        words[idx] = w;
    endtask

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy    <= 1'b0;
            waitCnt <= 2'd0;
            addrQ   <= '0;
            r       <= '0;
        end else if (!busy) begin
            if (ar.arvalid) begin
                busy    <= 1'b1;
                waitCnt <= respDelay;
                addrQ   <= ar.araddr;
            end
        end else if (r.rvalid) begin
            if (rReady) begin
                r.rvalid <= 1'b0;
                busy     <= 1'b0;
            end
        end else if (waitCnt != 2'd0) begin
            waitCnt <= waitCnt - 2'd1;
        end else begin
            r.rvalid <= 1'b1;
            r.rdata  <= inRange ? words[offset[63:2]] : 32'h0;
            r.rresp  <= !inRange ? 2'b11 : (inErr ? 2'b10 : 2'b00);  // DECERR, SLVERR
        end
    end

endmodule

/* tests/tbDecodeStage.sv */
`timescale 1ns/1ps

module tbDecodeStage;
    localparam logic [63:0] bootAddr       = 64'h0000_0000_8000_0000;
    localparam int          memDepth       = 48;
    localparam int          numProg        = 38;  // filler words after these
    localparam int          errIdx         = 36;
    localparam int          maxFillers     = 3;
    localparam int          drainLen       = 40;
    localparam int          watchdogCycles = memDepth * 50;

    logic                 clk;
    logic                 rstN;
    rvDecodePkg::axiArT   ar;
    logic                 arReady;
    rvDecodePkg::axiRT    r;
    logic                 rReady;
    logic                 outValid;
    logic                 outReady;
    rvDecodePkg::decodedT outData;
    logic [1:0]           respDelay;

    logic [31:0]          prog [memDepth];
    int                   itemIdx     = 0;
    int                   fillers     = 0;
    int                   drainCycles = 0;
    logic                 haltSeen    = 1'b0;
    logic                 arWait      = 1'b0;
    logic                 outWait     = 1'b0;
    rvDecodePkg::axiArT   arPrev;
    rvDecodePkg::decodedT outPrev;

    decodeStage #(
        .bootAddr (bootAddr)
    ) uut (
        .clk         (clk),
        .rstN        (rstN),
        .imemAr      (ar),
        .imemArReady (arReady),
        .imemR       (r),
        .imemRReady  (rReady),
        .outValid    (outValid),
        .outReady    (outReady),
        .outData     (outData)
    );

    imemModel #(
        .baseAddr (bootAddr),
        .depth    (memDepth),
        .errLo    (bootAddr + 4 * errIdx),
        .errHi    (bootAddr + 4 * errIdx + 4)
    ) imem (
        .clk       (clk),
        .rstN      (rstN),
        .ar        (ar),
        .arReady   (arReady),
        .r         (r),
        .rReady    (rReady),
        .respDelay (respDelay)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // addi whose rd and immediate fold in every address bit
    function automatic logic [31:0] fillWord(input logic [63:0] addr);
        logic [11:0] fold;
        fold = addr[11:0] ^ addr[23:12] ^ addr[35:24] ^ addr[47:36] ^ addr[59:48]
            ^ {8'b0, addr[63:60]};
        return encI(fold, 5'd0, 3'b000, addr[6:2], 7'b0010011);
    endfunction

    function automatic logic [63:0] expImm(input logic [31:0] w);
        case (w[6:2])
            5'b01101, 5'b00101: return {{32{w[31]}}, w[31:12], 12'b0};
            5'b11011: return {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            5'b11000: return {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            5'b01000: return {{52{w[31]}}, w[31:25], w[11:7]};
            default: return {{52{w[31]}}, w[31:20]};
        endcase
    endfunction

    function automatic logic expIllegal(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        if (w[1:0] != 2'b11)
            return 1'b1;
        case (w[6:2])
            5'b01101, 5'b00101, 5'b11011: return 1'b0;
            5'b11001: return f3 != 3'b000;
            5'b11000: return f3 == 3'b010 || f3 == 3'b011;
            5'b00000: return f3 == 3'b111;
            5'b01000: return f3[2];
            5'b00100: return (f3 == 3'b001 && f7[6:1] != 6'h00)
                || (f3 == 3'b101 && f7[6:1] != 6'h00 && f7[6:1] != 6'h10);
            5'b00110: return !(f3 == 3'b000 || (f3 == 3'b001 && f7 == 7'h00)
                || (f3 == 3'b101 && (f7 == 7'h00 || f7 == 7'h20)));
            5'b01100: return !(f7 == 7'h00 || f7 == 7'h01
                || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
            5'b01110: return !((f7 == 7'h00 && (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101))
                || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))
                || (f7 == 7'h01 && (f3 == 3'b000 || f3[2])));
            5'b11100: return f3 == 3'b100 || (f3 == 3'b000 && w != 32'h0000_0073
                && w != 32'h0010_0073 && w != 32'h3020_0073);
            default: return 1'b1;
        endcase
    endfunction

    function automatic rvDecodePkg::ctrlT expCtrl(input logic [31:0] w);
        rvDecodePkg::ctrlT c;
        logic [4:0]        op;
        logic [2:0]        f3;
        op      = w[6:2];
        f3      = w[14:12];
        c       = '0;
        c.memOp = f3;
        c.regWr = 1'b1;
        case (op)
            5'b01101, 5'b11100: begin  // lui and system pass the immediate
                c.aluBSrc = 2'd2;
                c.aluCtrl = 6'h0F;
            end
            5'b00101: begin
                c.aluASrc = 1'b1;
                c.aluBSrc = 2'd2;
            end
            5'b11011, 5'b11001: begin
                c.aluASrc = 1'b1;
                c.aluBSrc = 2'd1;
                c.branch  = op[1] ? rvDecodePkg::brJal : rvDecodePkg::brJalr;
            end
            5'b11000: begin
                c.regWr   = 1'b0;
                c.aluCtrl = {5'b00001, f3[1]};  // slt or sltu compare
                if (f3[2])
                    c.branch = f3[0] ? rvDecodePkg::brGe : rvDecodePkg::brLt;
                else
                    c.branch = f3[0] ? rvDecodePkg::brNe : rvDecodePkg::brEq;
            end
            5'b00000: begin
                c.aluBSrc  = 2'd2;
                c.memRd    = 1'b1;
                c.memToReg = 1'b1;
            end
            5'b01000: begin
                c.aluBSrc = 2'd2;
                c.memWr   = 1'b1;
                c.regWr   = 1'b0;
            end
            5'b00100, 5'b00110: begin  // op[1] marks the 32-bit forms
                c.aluBSrc = 2'd2;
                c.aluCtrl = {1'b0, op[1], w[30] && f3 == 3'b101, f3};
            end
            default: c.aluCtrl = {w[25], op[1], w[30], f3};
        endcase
        return c;
    endfunction

    task automatic failCheck(input string what);
        $display("Error at %0d ns: %s", $time, what);
        $display("Regression failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic checkItem(input rvDecodePkg::decodedT d);
        logic [31:0] w;
        logic [63:0] expPc;
        logic        busErrExp;
        assert (itemIdx < memDepth) else failCheck("more items than program words");
        w         = prog[itemIdx];
        expPc     = bootAddr + 4 * itemIdx;
        busErrExp = itemIdx == errIdx;
        assert (d.pc == expPc)
            else failCheck($sformatf("pc %h, expected %h", d.pc, expPc));
        assert ({d.rs1, d.rs2, d.rd, d.csrAddr} == {w[19:15], w[24:20], w[11:7], w[31:20]})
            else failCheck($sformatf("register or csr fields wrong at pc %h", d.pc));
        assert (d.imm == expImm(w))
            else failCheck($sformatf("imm %h, expected %h at pc %h", d.imm, expImm(w), d.pc));
        assert (d.busErr == busErrExp && d.illegal == (expIllegal(w) || busErrExp))
            else failCheck($sformatf("illegal/busErr %b%b wrong at pc %h",
                                     d.illegal, d.busErr, d.pc));
        assert (d.isCsr == (w[6:2] == 5'b11100) && d.ecall == (w == 32'h0000_0073)
                && d.mret == (w == 32'h3020_0073) && d.done == (w == 32'h0010_0073))
            else failCheck($sformatf("system flags wrong at pc %h", d.pc));
        if (!expIllegal(w))
            assert (d.ctrl == expCtrl(w))
                else failCheck($sformatf("ctrl %h, expected %h at pc %h",
                                         d.ctrl, expCtrl(w), d.pc));
    endtask

    task automatic buildProgram();
        prog[0]  = encU(20'hABCDE, 5'd5, 7'b0110111);                  // lui
        prog[1]  = encU(20'h12345, 5'd6, 7'b0010111);                  // auipc
        prog[2]  = encJ(21'h1FFFF0, 5'd1);                             // jal -16
        prog[3]  = encI(12'd12, 5'd1, 3'b000, 5'd2, 7'b1100111);       // jalr
        prog[4]  = encB(13'h1FF8, 5'd4, 5'd3, 3'b000);                 // beq -8
        prog[5]  = encB(13'd16, 5'd6, 5'd5, 3'b001);                   // bne
        prog[6]  = encB(13'h1000, 5'd8, 5'd7, 3'b100);                 // blt -4096
        prog[7]  = encB(13'd2044, 5'd10, 5'd9, 3'b111);                // bgeu
        prog[8]  = encI(12'hFFF, 5'd8, 3'b000, 5'd7, 7'b0000011);      // lb
        prog[9]  = encI(12'h7FF, 5'd10, 3'b011, 5'd9, 7'b0000011);     // ld
        prog[10] = encI(12'h010, 5'd2, 3'b110, 5'd11, 7'b0000011);     // lwu
        prog[11] = encS(12'hFFD, 5'd11, 5'd12, 3'b000);                // sb
        prog[12] = encS(12'h7F8, 5'd13, 5'd2, 3'b011);                 // sd
        prog[13] = encI(12'hF9C, 5'd14, 3'b000, 5'd13, 7'b0010011);    // addi -100
        prog[14] = encI(12'h43F, 5'd16, 3'b101, 5'd15, 7'b0010011);    // srai 63
        prog[15] = encI(12'h005, 5'd18, 3'b001, 5'd17, 7'b0010011);    // slli
        prog[16] = encI(12'h007, 5'd20, 3'b000, 5'd19, 7'b0011011);    // addiw
        prog[17] = encI(12'h403, 5'd22, 3'b101, 5'd21, 7'b0011011);    // sraiw
        prog[18] = encR(7'h00, 5'd3, 5'd2, 3'b000, 5'd1, 7'b0110011);  // add
        prog[19] = encR(7'h20, 5'd5, 5'd4, 3'b000, 5'd3, 7'b0110011);  // sub
        prog[20] = encR(7'h00, 5'd7, 5'd6, 3'b011, 5'd5, 7'b0110011);  // sltu
        prog[21] = encR(7'h01, 5'd9, 5'd8, 3'b000, 5'd7, 7'b0110011);  // mul
        prog[22] = encR(7'h01, 5'd11, 5'd10, 3'b101, 5'd9, 7'b0110011);   // divu
        prog[23] = encR(7'h00, 5'd13, 5'd12, 3'b000, 5'd11, 7'b0111011);  // addw
        prog[24] = encR(7'h20, 5'd15, 5'd14, 3'b000, 5'd13, 7'b0111011);  // subw
        prog[25] = encR(7'h20, 5'd17, 5'd16, 3'b101, 5'd15, 7'b0111011);  // sraw
        prog[26] = encR(7'h01, 5'd19, 5'd18, 3'b000, 5'd17, 7'b0111011);  // mulw
        prog[27] = encR(7'h01, 5'd21, 5'd20, 3'b111, 5'd19, 7'b0111011);  // remuw
        prog[28] = encI(12'h305, 5'd6, 3'b001, 5'd5, 7'b1110011);     // csrrw
        prog[29] = encI(12'h300, 5'd3, 3'b110, 5'd7, 7'b1110011);     // csrrsi
        prog[30] = 32'h0000_0073;                                     // ecall
        prog[31] = 32'h3020_0073;                                     // mret
        prog[32] = encB(13'd8, 5'd2, 5'd1, 3'b010);                   // bad funct3
        prog[33] = encR(7'h40, 5'd3, 5'd2, 3'b000, 5'd1, 7'b0110011); // bad funct7
        prog[34] = encI(12'd10, 5'd0, 3'b000, 5'd1, 7'b0010000);      // low bits 00
        prog[35] = 32'h1050_0073;                                     // wfi is not decoded
        prog[36] = encI(12'd5, 5'd0, 3'b000, 5'd3, 7'b0010011);       // read gets SLVERR
        prog[37] = 32'h0010_0073;                                     // ebreak
        for (int i = numProg; i < memDepth; i++)
            prog[i] = fillWord(bootAddr + 4 * i);
        for (int i = 0; i < memDepth; i++)
            imem.writeWord(i, prog[i]);
    endtask

    // all outputs sampled mid-cycle away from the driving edge
    always @(negedge clk) begin
        if (!rstN) begin
            assert (!ar.arvalid && !rReady && !outValid)
                else failCheck("arvalid, rready or outValid high during reset");
        end else begin
            if (arWait)
                assert (ar == arPrev) else failCheck("AR request dropped or changed");
            if (outWait)
                assert (outValid && outData == outPrev)
                    else failCheck("output item dropped or changed before acceptance");
            if (haltSeen) begin
                assert (!ar.arvalid) else failCheck("address read issued after ebreak");
                drainCycles++;
            end
            if (outValid && outReady) begin
                checkItem(outData);
                if (haltSeen)
                    fillers++;
                if (outData.done)
                    haltSeen = 1'b1;
                itemIdx++;
            end
            arWait  = ar.arvalid && !arReady;
            arPrev  = ar;
            outWait = outValid && !outReady;
            outPrev = outData;
        end
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: the decoded stream did not reach ebreak and drain in time");
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(62861));
        rstN      = 1'b0;
        outReady  = 1'b0;
        respDelay = 2'd0;
        buildProgram();
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        while (drainCycles < drainLen) begin
            @(posedge clk);
            #1;
            outReady  = $urandom_range(9) >= 3;  // low about 30% of cycles
            respDelay = 2'($urandom_range(3));
        end
        assert (fillers <= maxFillers) begin
            $display("Regression passed");
            $finish;
        end else begin
            failCheck($sformatf("%0d filler items delivered after ebreak", fillers));
        end
    end

endmodule

/* list.f */
hdl/rvDecodePkg.sv
hdl/immGen.sv
hdl/ctrlDecode.sv
hdl/instrDecode.sv
hdl/instrFetch.sv
hdl/pipeReg.sv
hdl/decodeStage.sv
tests/imemModel.sv
tests/tbDecodeStage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - hdl/rvDecodePkg.sv
      - hdl/immGen.sv
      - hdl/ctrlDecode.sv
      - hdl/instrDecode.sv
      - hdl/instrFetch.sv
      - hdl/pipeReg.sv
      - hdl/decodeStage.sv

  - target: test
    files:
      - tests/imemModel.sv
      - tests/tbDecodeStage.sv
